// ==== dma_pkg.sv ====
/*
 * dma package
 * widths, register map, control bit positions and FSM states
 * shared by the seven channel DMA engine
 */
package dma_pkg;
   localparam int NUM_CHAN = 7;

   typedef logic [31:0]         word_t;     // data or address word
   typedef logic [15:0]         count_t;    // word count in BCR[31:16]
   typedef logic [2:0]          prio_t;     // lower value wins
   typedef logic [NUM_CHAN-1:0] chan_vec_t; // one bit per channel
   typedef logic [7:0]          reg_addr_t;

   // register map
   localparam reg_addr_t CHAN_STRIDE = 8'h10;
   localparam reg_addr_t OFS_MADR    = 8'h00;
   localparam reg_addr_t OFS_BCR     = 8'h04;
   localparam reg_addr_t OFS_CHCR    = 8'h08;
   localparam reg_addr_t ADDR_DPCR   = 8'h70;
   localparam reg_addr_t ADDR_DICR   = 8'h74;

   localparam int CHCR_DIR   = 0;  // 1 = memory to device
   localparam int CHCR_STEP  = 1;  // 1 = address counts down
   localparam int CHCR_START = 24;

   localparam int DPCR_FIELD = 4;  // prio in [2:0], enable in [3]

   localparam int DICR_FORCE    = 15;
   localparam int DICR_EN_LSB   = 16;
   localparam int DICR_MASTER   = 23;
   localparam int DICR_FLAG_LSB = 24;
   localparam int DICR_IRQ      = 31;

   localparam word_t ADDR_STEP = 32'd4;

   typedef enum logic [2:0] {
      CH_IDLE, CH_WAIT_GO, CH_DEV_RD, CH_MEM_WR,
      CH_MEM_RD, CH_DEV_WR, CH_ACK_LOW, CH_FINISH
   } chan_state_t;

   typedef enum logic [1:0] {
      ARB_IDLE, ARB_ASSIGN, ARB_WAIT
   } arb_state_t;
endpackage

// ==== dma_chan_if.sv ====
/*
 * dma channel link
 * carries one channel's MADR, count and CHCR bits to its transfer FSM
 * and the advance and finish strobes back to the register bank
 */
`timescale 1ns/10ps

interface dma_chan_if;
   dma_pkg::word_t  madr;
   dma_pkg::count_t count;
   logic            dir;       // memory to device
   logic            step_down;
   logic            start;
   logic            advance;   // one word moved
   logic            finish;    // clear start bit

   modport regs (output madr, count, dir, step_down, start,
                 input  advance, finish);

   modport fsm  (input  madr, count, dir, step_down, start,
                 output advance, finish);
endinterface

// ==== dma_regs.sv ====
/*
 * dma register bank
 * per channel MADR, BCR and CHCR plus DPCR, written by the CPU,
 * stepped by the channel strobes, with the register read mux
 */
`timescale 1ns/10ps

module dma_regs (
   input  logic               sys_clk,
   input  logic               rst,
   input  logic               reg_wen_i,
   input  dma_pkg::reg_addr_t reg_addr_i,
   input  dma_pkg::word_t     reg_wdata_i,
   output dma_pkg::word_t     rdata_o,
   output dma_pkg::word_t     dpcr_o,
   dma_chan_if.regs           chan [dma_pkg::NUM_CHAN]
);
   dma_pkg::word_t dpcr_q;
   dma_pkg::word_t rd_word [dma_pkg::NUM_CHAN]; // zero unless addressed

   always_ff @(posedge sys_clk, posedge rst) begin
      if (rst) begin
         dpcr_q <= '0;
      end else if (reg_wen_i && reg_addr_i == dma_pkg::ADDR_DPCR) begin
         dpcr_q <= reg_wdata_i;
      end
   end

   for (genvar i = 0; i < dma_pkg::NUM_CHAN; i++) begin : g_bank
      localparam dma_pkg::reg_addr_t BASE = dma_pkg::reg_addr_t'(i) * dma_pkg::CHAN_STRIDE;

      dma_pkg::word_t  madr_q;
      dma_pkg::count_t count_q;
      logic            dir_q, step_q, start_q;
      logic            sel_madr, sel_bcr, sel_chcr;
      dma_pkg::word_t  chcr_word;

      assign sel_madr = reg_addr_i == BASE + dma_pkg::OFS_MADR;
      assign sel_bcr  = reg_addr_i == BASE + dma_pkg::OFS_BCR;
      assign sel_chcr = reg_addr_i == BASE + dma_pkg::OFS_CHCR;

      // cpu write wins over the channel strobes
      always_ff @(posedge sys_clk, posedge rst) begin
         if (rst) begin
            madr_q  <= '0;
            count_q <= '0;
            dir_q   <= 1'b0;
            step_q  <= 1'b0;
            start_q <= 1'b0;
         end else begin
            if (reg_wen_i && sel_madr) begin
               madr_q <= reg_wdata_i;
            end else if (chan[i].advance) begin
               madr_q <= chan[i].step_down ? madr_q - dma_pkg::ADDR_STEP
                                           : madr_q + dma_pkg::ADDR_STEP;
            end
            if (reg_wen_i && sel_bcr) begin
               count_q <= reg_wdata_i[31:16]; // block size half not kept
            end else if (chan[i].advance) begin
               count_q <= count_q - 16'd1;
            end
            if (reg_wen_i && sel_chcr) begin
               dir_q   <= reg_wdata_i[dma_pkg::CHCR_DIR];
               step_q  <= reg_wdata_i[dma_pkg::CHCR_STEP];
               start_q <= reg_wdata_i[dma_pkg::CHCR_START];
            end else if (chan[i].finish) begin
               start_q <= 1'b0;
            end
         end
      end

      always_comb begin
         chcr_word = '0;
         chcr_word[dma_pkg::CHCR_DIR]   = dir_q;
         chcr_word[dma_pkg::CHCR_STEP]  = step_q;
         chcr_word[dma_pkg::CHCR_START] = start_q;
      end

      assign rd_word[i] = sel_madr ? madr_q :
                          sel_bcr  ? {count_q, 16'h0000} :
                          sel_chcr ? chcr_word : '0;

      assign chan[i].madr      = madr_q;
      assign chan[i].count     = count_q;
      assign chan[i].dir       = dir_q;
      assign chan[i].step_down = step_q;
      assign chan[i].start     = start_q;
   end

   // DICR is merged in at the top level
   always_comb begin
      rdata_o = (reg_addr_i == dma_pkg::ADDR_DPCR) ? dpcr_q : '0;
      for (int i = 0; i < dma_pkg::NUM_CHAN; i++) begin
         rdata_o = rdata_o | rd_word[i];
      end
   end

   assign dpcr_o = dpcr_q;
endmodule

// ==== dma_channel.sv ====
/*
 * dma channel
 * sync mode 1 transfer FSM, one word per grant between the device
 * FIFO and memory, with the word latch and end of block handling
 */
`timescale 1ns/10ps

module dma_channel (
   input  logic           sys_clk,
   input  logic           rst,
   input  logic           go_i,
   output logic           req_o,
   output logic           done_o,
   output logic           irq_o,
   dma_chan_if.fsm        regs,
   output dma_pkg::word_t mem_addr_o,
   output dma_pkg::word_t mem_wdata_o,
   output logic           mem_ren_o,
   output logic           mem_wen_o,
   input  dma_pkg::word_t mem_rdata_i,
   input  logic           mem_ack_i,
   input  logic           chan_rdy_i,
   input  logic           chan_full_i,
   input  dma_pkg::word_t chan_rdata_i,
   output dma_pkg::word_t chan_wdata_o,
   output logic           chan_ren_o,
   output logic           chan_wen_o
);
   dma_pkg::chan_state_t state_q, state_d;
   logic                 tip_q, tip_d;   // transfer in progress
   dma_pkg::word_t       data_q;

   always_ff @(posedge sys_clk, posedge rst) begin
      if (rst) begin
         state_q <= dma_pkg::CH_IDLE;
         tip_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         tip_q   <= tip_d;
      end
   end

   // word latch, filled from the device or from memory
   always_ff @(posedge sys_clk) begin
      if (state_q == dma_pkg::CH_DEV_RD && chan_rdy_i) begin
         data_q <= chan_rdata_i;
      end else if (state_q == dma_pkg::CH_MEM_RD && mem_ack_i) begin
         data_q <= mem_rdata_i;
      end
   end

   always_comb begin
      state_d      = state_q;
      tip_d        = tip_q;
      done_o       = 1'b0;
      irq_o        = 1'b0;
      regs.advance = 1'b0;
      regs.finish  = 1'b0;
      chan_ren_o   = 1'b0;
      chan_wen_o   = 1'b0;

      case (state_q)
         dma_pkg::CH_IDLE: begin
            if (regs.start) begin
               tip_d   = 1'b1;
               state_d = dma_pkg::CH_WAIT_GO;
            end
         end
         dma_pkg::CH_WAIT_GO: begin
            if (go_i) begin
               if (regs.count == '0) begin
                  state_d = dma_pkg::CH_FINISH;  // block already done
               end else if (regs.dir) begin
                  state_d = dma_pkg::CH_MEM_RD;
               end else begin
                  state_d = dma_pkg::CH_DEV_RD;
               end
            end
         end
         dma_pkg::CH_DEV_RD: begin
            if (chan_rdy_i) begin
               chan_ren_o = 1'b1;
               state_d    = dma_pkg::CH_MEM_WR;
            end
         end
         dma_pkg::CH_MEM_WR: begin
            if (mem_ack_i) begin
               state_d = dma_pkg::CH_ACK_LOW;
            end
         end
         dma_pkg::CH_MEM_RD: begin
            if (mem_ack_i) begin
               state_d = dma_pkg::CH_DEV_WR;
            end
         end
         dma_pkg::CH_DEV_WR: begin
            if (!chan_full_i) begin
               chan_wen_o = 1'b1;
               state_d    = dma_pkg::CH_ACK_LOW;
            end
         end
         dma_pkg::CH_ACK_LOW: begin
            if (!mem_ack_i) begin     // memory released the ack
               done_o       = 1'b1;
               regs.advance = 1'b1;
               state_d      = dma_pkg::CH_WAIT_GO;
            end
         end
         dma_pkg::CH_FINISH: begin
            done_o      = 1'b1;
            irq_o       = 1'b1;
            regs.finish = 1'b1;
            tip_d       = 1'b0;
            state_d     = dma_pkg::CH_IDLE;
         end
         default: state_d = dma_pkg::CH_IDLE;
      endcase
   end

   assign req_o        = tip_q;
   assign mem_addr_o   = regs.madr;
   assign mem_wdata_o  = data_q;
   assign mem_ren_o    = state_q == dma_pkg::CH_MEM_RD;  // held until ack
   assign mem_wen_o    = state_q == dma_pkg::CH_MEM_WR;
   assign chan_wdata_o = data_q;
endmodule

// ==== dma_arbiter.sv ====
/*
 * dma arbiter
 * DPCR priority pick among requesting channels, grant FSM per bus
 * tenure, and the memory bus mux driven by the registered grant
 */
`timescale 1ns/10ps

module dma_arbiter (
   input  logic                                      sys_clk,
   input  logic                                      rst,
   input  dma_pkg::word_t                            dpcr_i,
   input  logic                                      dma_en_i,
   input  dma_pkg::chan_vec_t                        req_i,
   input  dma_pkg::chan_vec_t                        done_i,
   output dma_pkg::chan_vec_t                        go_o,
   input  dma_pkg::word_t [dma_pkg::NUM_CHAN-1:0]    ch_addr_i,
   input  dma_pkg::word_t [dma_pkg::NUM_CHAN-1:0]    ch_wdata_i,
   input  dma_pkg::chan_vec_t                        ch_ren_i,
   input  dma_pkg::chan_vec_t                        ch_wen_i,
   output dma_pkg::word_t                            mem_addr_o,
   output dma_pkg::word_t                            mem_wdata_o,
   output logic                                      mem_ren_o,
   output logic                                      mem_wen_o,
   output logic                                      dma_done_o
);
   dma_pkg::arb_state_t state_q, state_d;
   dma_pkg::chan_vec_t  grant_q, grant_d;
   dma_pkg::chan_vec_t  win;
   dma_pkg::prio_t      best;
   logic                found;

   // strict compare keeps the lower index on a tie
   always_comb begin
      win   = '0;
      best  = '0;
      found = 1'b0;
      for (int i = 0; i < dma_pkg::NUM_CHAN; i++) begin
         if (req_i[i] && dpcr_i[i*dma_pkg::DPCR_FIELD + 3] &&
             (!found || dpcr_i[i*dma_pkg::DPCR_FIELD +: 3] < best)) begin
            win    = '0;
            win[i] = 1'b1;
            best   = dpcr_i[i*dma_pkg::DPCR_FIELD +: 3];
            found  = 1'b1;
         end
      end
   end

   always_ff @(posedge sys_clk, posedge rst) begin
      if (rst) begin
         state_q <= dma_pkg::ARB_IDLE;
         grant_q <= '0;
      end else begin
         state_q <= state_d;
         grant_q <= grant_d;
      end
   end

   always_comb begin
      state_d    = state_q;
      grant_d    = grant_q;
      go_o       = '0;
      dma_done_o = 1'b0;
      case (state_q)
         dma_pkg::ARB_IDLE: begin
            if (dma_en_i) begin
               state_d = dma_pkg::ARB_ASSIGN;
            end
         end
         dma_pkg::ARB_ASSIGN: begin
            if (found) begin
               grant_d = win;
               go_o    = win;
               state_d = dma_pkg::ARB_WAIT;
            end else begin
               dma_done_o = 1'b1;   // nothing eligible, hand the bus back
               state_d    = dma_pkg::ARB_IDLE;
            end
         end
         dma_pkg::ARB_WAIT: begin
            if (|(done_i & grant_q)) begin
               dma_done_o = 1'b1;
               grant_d    = '0;
               state_d    = dma_pkg::ARB_IDLE;
            end
         end
         default: state_d = dma_pkg::ARB_IDLE;
      endcase
   end

   // bus idles at zero without a grant
   always_comb begin
      mem_addr_o  = '0;
      mem_wdata_o = '0;
      mem_ren_o   = 1'b0;
      mem_wen_o   = 1'b0;
      for (int i = 0; i < dma_pkg::NUM_CHAN; i++) begin
         if (grant_q[i]) begin
            mem_addr_o  = ch_addr_i[i];
            mem_wdata_o = ch_wdata_i[i];
            mem_ren_o   = ch_ren_i[i];
            mem_wen_o   = ch_wen_i[i];
         end
      end
   end
endmodule

// ==== dma_irq.sv ====
/*
 * dma interrupt register
 * DICR with per channel enables, flag capture under the master bit,
 * write one to clear flags, and the combined irq in bit 31
 */
`timescale 1ns/10ps

module dma_irq (
   input  logic               sys_clk,
   input  logic               rst,
   input  dma_pkg::chan_vec_t irq_i,
   input  logic               wen_i,
   input  dma_pkg::word_t     wdata_i,
   output dma_pkg::word_t     dicr_o,
   output logic               irq_o
);
   dma_pkg::word_t     dicr_q, dicr_d;
   dma_pkg::chan_vec_t enables, flags;

   assign enables = dicr_q[dma_pkg::DICR_EN_LSB +: dma_pkg::NUM_CHAN];
   assign flags   = dicr_q[dma_pkg::DICR_FLAG_LSB +: dma_pkg::NUM_CHAN];

   always_comb begin
      dicr_d = dicr_q;
      // master irq lags its inputs by one cycle
      dicr_d[dma_pkg::DICR_IRQ] = dicr_q[dma_pkg::DICR_FORCE] | (|(enables & flags));
      if (wen_i) begin
         dicr_d[5:0] = wdata_i[5:0];   // low control bits
         dicr_d[dma_pkg::DICR_MASTER:dma_pkg::DICR_FORCE] =
            wdata_i[dma_pkg::DICR_MASTER:dma_pkg::DICR_FORCE];
         dicr_d[dma_pkg::DICR_FLAG_LSB +: dma_pkg::NUM_CHAN] =
            flags & ~wdata_i[dma_pkg::DICR_FLAG_LSB +: dma_pkg::NUM_CHAN];
      end else if (dicr_q[dma_pkg::DICR_MASTER]) begin
         dicr_d[dma_pkg::DICR_FLAG_LSB +: dma_pkg::NUM_CHAN] = flags | (enables & irq_i);
      end
   end

   always_ff @(posedge sys_clk, posedge rst) begin
      if (rst) begin
         dicr_q <= '0;
      end else begin
         dicr_q <= dicr_d;
      end
   end

   assign dicr_o = dicr_q;
   assign irq_o  = dicr_q[dma_pkg::DICR_IRQ];
endmodule

// ==== dma_top.sv ====
/*
 * dma top
 * seven channel DMA engine: register bank, DPCR arbiter,
 * per channel transfer FSMs and the DICR interrupt block
 */
`timescale 1ns/10ps

module dma_top (
   input  logic                                   sys_clk,
   input  logic                                   rst,
   input  logic                                   reg_wen_i,
   input  dma_pkg::reg_addr_t                     reg_addr_i,
   input  dma_pkg::word_t                         reg_wdata_i,
   output dma_pkg::word_t                         reg_rdata_o,
   input  logic                                   dma_en_i,
   output logic                                   dma_req_o,
   output logic                                   dma_done_o,
   output dma_pkg::word_t                         mem_addr_o,
   output dma_pkg::word_t                         mem_wdata_o,
   input  dma_pkg::word_t                         mem_rdata_i,
   output logic                                   mem_ren_o,
   output logic                                   mem_wen_o,
   input  logic                                   mem_ack_i,
   input  dma_pkg::chan_vec_t                     chan_rdy_i,
   input  dma_pkg::chan_vec_t                     chan_full_i,
   output dma_pkg::chan_vec_t                     chan_ren_o,
   output dma_pkg::chan_vec_t                     chan_wen_o,
   input  dma_pkg::word_t [dma_pkg::NUM_CHAN-1:0] chan_rdata_i,
   output dma_pkg::word_t [dma_pkg::NUM_CHAN-1:0] chan_wdata_o,
   output logic                                   irq_o
);
   dma_pkg::chan_vec_t                     req, done, go, ch_irq, ch_ren, ch_wen;
   dma_pkg::word_t [dma_pkg::NUM_CHAN-1:0] ch_addr, ch_wdata;
   dma_pkg::word_t                         dpcr, regs_rdata, dicr;
   logic                                   dicr_sel;

   dma_chan_if chan_if [dma_pkg::NUM_CHAN] ();

   assign dicr_sel    = reg_addr_i == dma_pkg::ADDR_DICR;
   assign reg_rdata_o = dicr_sel ? dicr : regs_rdata;
   assign dma_req_o   = |req;

   dma_regs i_regs (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .reg_wen_i   (reg_wen_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wdata_i (reg_wdata_i),
      .rdata_o     (regs_rdata),
      .dpcr_o      (dpcr),
      .chan        (chan_if)
   );

   dma_arbiter i_arbiter (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .dpcr_i      (dpcr),
      .dma_en_i    (dma_en_i),
      .req_i       (req),
      .done_i      (done),
      .go_o        (go),
      .ch_addr_i   (ch_addr),
      .ch_wdata_i  (ch_wdata),
      .ch_ren_i    (ch_ren),
      .ch_wen_i    (ch_wen),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o),
      .mem_ren_o   (mem_ren_o),
      .mem_wen_o   (mem_wen_o),
      .dma_done_o  (dma_done_o)
   );

   dma_irq i_irq (
      .sys_clk (sys_clk),
      .rst     (rst),
      .irq_i   (ch_irq),
      .wen_i   (reg_wen_i && dicr_sel),
      .wdata_i (reg_wdata_i),
      .dicr_o  (dicr),
      .irq_o   (irq_o)
   );

   for (genvar i = 0; i < dma_pkg::NUM_CHAN; i++) begin : g_chan
      dma_channel i_channel (
         .sys_clk      (sys_clk),
         .rst          (rst),
         .go_i         (go[i]),
         .req_o        (req[i]),
         .done_o       (done[i]),
         .irq_o        (ch_irq[i]),
         .regs         (chan_if[i]),
         .mem_addr_o   (ch_addr[i]),
         .mem_wdata_o  (ch_wdata[i]),
         .mem_ren_o    (ch_ren[i]),
         .mem_wen_o    (ch_wen[i]),
         .mem_rdata_i  (mem_rdata_i),   // shared read data
         .mem_ack_i    (mem_ack_i),
         .chan_rdy_i   (chan_rdy_i[i]),
         .chan_full_i  (chan_full_i[i]),
         .chan_rdata_i (chan_rdata_i[i]),
         .chan_wdata_o (chan_wdata_o[i]),
         .chan_ren_o   (chan_ren_o[i]),
         .chan_wen_o   (chan_wen_o[i])
      );
   end
endmodule

// ==== dma_tb.sv ====
/*
 * dma testbench
 * memory and device models with LFSR back-pressure, a table of
 * single channel transfers, register, priority and DICR checks
 */
`timescale 1ns/10ps

module dma_tb;
   typedef struct {
      int              ch;
      logic            dir;       // memory to device
      logic            step;      // address counts down
      dma_pkg::word_t  madr;
      dma_pkg::count_t count;
      dma_pkg::word_t  dpcr;
      dma_pkg::word_t  exp_madr;
      logic            ien;       // DICR enable for this channel
   } row_t;

   logic                                   sys_clk = 1'b0;
   logic                                   rst;
   logic                                   reg_wen, dma_en;
   dma_pkg::reg_addr_t                     reg_addr;
   dma_pkg::word_t                         reg_wdata, reg_rdata;
   logic                                   dma_req, dma_done, mem_ren, mem_wen, irq;
   dma_pkg::word_t                         mem_addr, mem_wdata;
   dma_pkg::word_t                         mem_rdata = '0;
   logic                                   mem_ack = 1'b0;
   dma_pkg::chan_vec_t                     chan_rdy = '0;
   dma_pkg::chan_vec_t                     chan_full = '0;
   dma_pkg::chan_vec_t                     chan_ren, chan_wen;
   dma_pkg::word_t [dma_pkg::NUM_CHAN-1:0] chan_rdata, chan_wdata;

   dma_pkg::word_t mem [256];
   logic [1:0]     ack_wait = '0;
   logic [31:0]    lfsr_q = 32'h72a4;
   int             src_idx [dma_pkg::NUM_CHAN] = '{default: 0};
   dma_pkg::word_t rx_q [dma_pkg::NUM_CHAN][$]; // words seen by each device
   row_t           rows [5];
   int             err_cnt = 0;
   int             wen_err_cnt = 0;
   int             chk_cnt = 0;
   logic           timed_out = 1'b0;

   always #10 sys_clk = ~sys_clk;

   dma_top i_dut (
      .sys_clk(sys_clk), .rst(rst),
      .reg_wen_i(reg_wen), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
      .reg_rdata_o(reg_rdata),
      .dma_en_i(dma_en), .dma_req_o(dma_req), .dma_done_o(dma_done),
      .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata),
      .mem_ren_o(mem_ren), .mem_wen_o(mem_wen), .mem_ack_i(mem_ack),
      .chan_rdy_i(chan_rdy), .chan_full_i(chan_full),
      .chan_ren_o(chan_ren), .chan_wen_o(chan_wen),
      .chan_rdata_i(chan_rdata), .chan_wdata_o(chan_wdata),
      .irq_o(irq)
   );

   // galois LFSR stepped once for each bit taken
   function automatic logic take_bit();
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
      return lfsr_q[0];
   endfunction

   function automatic dma_pkg::word_t fill(dma_pkg::word_t a);
      return a ^ 32'hc3a5_0000 ^ (a << 12);
   endfunction

   function automatic dma_pkg::word_t src_word(int c, int i);
      return {4'hd, 4'(c), 8'h00, 16'(i)};
   endfunction

   function automatic dma_pkg::reg_addr_t chan_addr(int ch, dma_pkg::reg_addr_t ofs);
      return dma_pkg::reg_addr_t'(ch) * dma_pkg::CHAN_STRIDE + ofs;
   endfunction

   task automatic check_word(string what, dma_pkg::word_t got, dma_pkg::word_t exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   always_comb begin
      for (int c = 0; c < dma_pkg::NUM_CHAN; c++) begin
         chan_rdata[c] = src_word(c, src_idx[c]);   // device source head
      end
   end

   // memory and device models
   always @(posedge sys_clk) begin
      logic [1:0] dly;
      if (rst) begin
         mem_ack <= 1'b0;
      end else begin
         for (int c = 0; c < dma_pkg::NUM_CHAN; c++) begin
            chan_rdy[c]  <= take_bit();
            chan_full[c] <= take_bit();
            if (chan_ren[c]) begin
               src_idx[c] <= src_idx[c] + 1;
            end
            if (chan_wen[c]) begin
               if (chan_full[c]) begin
                  wen_err_cnt++;
                  $display("[ERROR] %0t: chan_wen on channel %0d while full", $time, c);
               end
               rx_q[c].push_back(chan_wdata[c]);
            end
         end
         if (mem_ren || mem_wen) begin
            if (!mem_ack) begin
               if (ack_wait == 2'd0) begin
                  mem_ack <= 1'b1;
                  if (mem_wen) begin
                     mem[mem_addr[9:2]] <= mem_wdata;
                  end else begin
                     mem_rdata <= mem[mem_addr[9:2]];
                  end
               end else begin
                  ack_wait <= ack_wait - 2'd1;
               end
            end
         end else begin
            mem_ack <= 1'b0;
            dly[0] = take_bit();
            dly[1] = take_bit();
            ack_wait <= dly;      // delay for the next request
         end
      end
   end

   task automatic write_reg(dma_pkg::reg_addr_t a, dma_pkg::word_t d);
      @(posedge sys_clk);
      reg_wen   <= 1'b1;
      reg_addr  <= a;
      reg_wdata <= d;
      @(posedge sys_clk);
      reg_wen <= 1'b0;
   endtask

   // one spare cycle so DICR bit 31 has settled
   task automatic read_reg(dma_pkg::reg_addr_t a, output dma_pkg::word_t d);
      @(posedge sys_clk);
      reg_addr <= a;
      @(posedge sys_clk);
      @(posedge sys_clk);
      d = reg_rdata;
   endtask

   task automatic wait_req();
      int n;
      n = 0;
      while (!dma_req && n < 50) begin
         @(posedge sys_clk);
         n++;
      end
      if (!dma_req) begin
         timed_out = 1'b1;
         $display("timeout: no channel raised its request");
      end
   endtask

   task automatic run_grant();
      int n;
      n = 0;
      @(posedge sys_clk);
      dma_en <= 1'b1;
      @(posedge sys_clk);
      dma_en <= 1'b0;
      do begin
         @(posedge sys_clk);
         n++;
      end while (!dma_done && n < 200);
      if (!dma_done) begin
         timed_out = 1'b1;
         $display("timeout: dma_done never came after a grant");
      end
      @(posedge sys_clk);
   endtask

   task automatic serve_all();
      int g;
      g = 0;
      wait_req();
      while (dma_req && g < 64 && !timed_out) begin
         run_grant();
         g++;
      end
      if (dma_req) begin
         timed_out = 1'b1;
         $display("timeout: channels still requesting after 64 grants");
      end
   endtask

   task automatic start_chan(int ch, dma_pkg::word_t madr, dma_pkg::count_t cnt);
      write_reg(chan_addr(ch, dma_pkg::OFS_MADR), madr);
      write_reg(chan_addr(ch, dma_pkg::OFS_BCR), {cnt, 16'h0000});
      write_reg(chan_addr(ch, dma_pkg::OFS_CHCR), 32'h0100_0000);  // start with dir and step clear
   endtask

   task automatic check_registers();
      dma_pkg::word_t v;
      write_reg(chan_addr(6, dma_pkg::OFS_MADR), 32'h1234_5678);
      read_reg(chan_addr(6, dma_pkg::OFS_MADR), v);
      check_word("MADR readback", v, 32'h1234_5678);
      write_reg(chan_addr(6, dma_pkg::OFS_BCR), 32'habcd_1234);
      read_reg(chan_addr(6, dma_pkg::OFS_BCR), v);
      check_word("BCR readback", v, 32'habcd_0000);
      write_reg(chan_addr(6, dma_pkg::OFS_CHCR), 32'h00ff_ffff);  // start bit stays low
      read_reg(chan_addr(6, dma_pkg::OFS_CHCR), v);
      check_word("CHCR readback", v, 32'h0000_0003);
      write_reg(dma_pkg::ADDR_DPCR, 32'h0fed_cba9);
      read_reg(dma_pkg::ADDR_DPCR, v);
      check_word("DPCR readback", v, 32'h0fed_cba9);
      write_reg(dma_pkg::ADDR_DICR, 32'hffff_ffff);
      read_reg(dma_pkg::ADDR_DICR, v);
      check_word("DICR masked write", v, 32'h80ff_803f);
      write_reg(dma_pkg::ADDR_DICR, 32'h0000_0000);
      read_reg(dma_pkg::ADDR_DICR, v);
      check_word("DICR cleared", v, 32'h0000_0000);
   endtask

   task automatic run_row(int r);
      row_t           t;
      int             first;
      int             rx_first;
      dma_pkg::word_t v, a, en_bit, flag_bit;
      t        = rows[r];
      first    = src_idx[t.ch];
      rx_first = rx_q[t.ch].size();
      en_bit   = t.ien ? 32'h1 << (dma_pkg::DICR_EN_LSB + t.ch) : 32'h0;
      flag_bit = 32'h1 << (dma_pkg::DICR_FLAG_LSB + t.ch);
      write_reg(dma_pkg::ADDR_DICR, (32'h1 << dma_pkg::DICR_MASTER) | en_bit);
      write_reg(dma_pkg::ADDR_DPCR, t.dpcr);
      write_reg(chan_addr(t.ch, dma_pkg::OFS_MADR), t.madr);
      write_reg(chan_addr(t.ch, dma_pkg::OFS_BCR), {t.count, 16'h0000});
      write_reg(chan_addr(t.ch, dma_pkg::OFS_CHCR),
                32'h0100_0000 | {30'd0, t.step, t.dir});
      serve_all();
      read_reg(chan_addr(t.ch, dma_pkg::OFS_MADR), v);
      check_word("final MADR", v, t.exp_madr);
      read_reg(chan_addr(t.ch, dma_pkg::OFS_BCR), v);
      check_word("final BCR", v, 32'h0);
      read_reg(chan_addr(t.ch, dma_pkg::OFS_CHCR), v);
      check_word("start bit", {31'd0, v[dma_pkg::CHCR_START]}, 32'h0);
      if (!t.dir) begin
         for (int k = 0; k < int'(t.count); k++) begin
            a = t.step ? t.madr - 32'(k) * 4 : t.madr + 32'(k) * 4;
            check_word("memory word", mem[a[9:2]], src_word(t.ch, first + k));
         end
      end else begin
         check_word("device word count", 32'(rx_q[t.ch].size() - rx_first), 32'(t.count));
         for (int k = 0; k < rx_q[t.ch].size() - rx_first; k++) begin
            a = t.step ? t.madr - 32'(k) * 4 : t.madr + 32'(k) * 4;
            check_word("device word", rx_q[t.ch][rx_first + k], fill(a));
         end
      end
      read_reg(dma_pkg::ADDR_DICR, v);
      check_word("DICR flag", v & flag_bit, t.ien ? flag_bit : 32'h0);
      check_word("irq_o", {31'd0, irq}, {31'd0, t.ien});
      if (t.ien) begin
         write_reg(dma_pkg::ADDR_DICR, (32'h1 << dma_pkg::DICR_MASTER) | en_bit | flag_bit);
         read_reg(dma_pkg::ADDR_DICR, v);
         check_word("DICR after flag clear", v & flag_bit, 32'h0);
         check_word("irq_o after flag clear", {31'd0, irq}, 32'h0);
      end
      write_reg(dma_pkg::ADDR_DICR, 32'h0);
   endtask

   task automatic check_priority();
      dma_pkg::word_t v;
      // ch5 at prio 1 beats ch2 at prio 5
      write_reg(dma_pkg::ADDR_DPCR, 32'h0090_0d00);
      start_chan(2, 32'h0000_0380, 16'd1);
      start_chan(5, 32'h0000_0390, 16'd1);
      wait_req();
      repeat (2) @(posedge sys_clk);
      run_grant();
      read_reg(chan_addr(5, dma_pkg::OFS_BCR), v);
      check_word("prio winner BCR", v, 32'h0);
      read_reg(chan_addr(2, dma_pkg::OFS_BCR), v);
      check_word("prio loser BCR", v, 32'h0001_0000);
      serve_all();
      // equal priority goes to the lower index
      write_reg(dma_pkg::ADDR_DPCR, 32'h0000_a0a0);
      start_chan(1, 32'h0000_03a0, 16'd1);
      start_chan(3, 32'h0000_03b0, 16'd1);
      wait_req();
      repeat (2) @(posedge sys_clk);
      run_grant();
      read_reg(chan_addr(1, dma_pkg::OFS_BCR), v);
      check_word("tie winner BCR", v, 32'h0);
      read_reg(chan_addr(3, dma_pkg::OFS_BCR), v);
      check_word("tie loser BCR", v, 32'h0001_0000);
      serve_all();
      // ch4 left disabled in DPCR
      write_reg(dma_pkg::ADDR_DPCR, 32'h0003_0000);
      start_chan(4, 32'h0000_03c0, 16'd1);
      wait_req();
      run_grant();
      read_reg(chan_addr(4, dma_pkg::OFS_BCR), v);
      check_word("disabled channel BCR", v, 32'h0001_0000);
   endtask

   initial begin
      rst       = 1'b1;
      reg_wen   = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      dma_en    = 1'b0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = fill(32'(i) << 2);
      end
      //         ch dir  step madr          cnt    dpcr          exp madr      ien
      rows[0] = '{0, 1'b0, 1'b0, 32'h0000_0100, 16'd4, 32'h0000_0008, 32'h0000_0110, 1'b1};
      rows[1] = '{3, 1'b1, 1'b1, 32'h0000_02fc, 16'd5, 32'h0000_8000, 32'h0000_02e8, 1'b0};
      rows[2] = '{6, 1'b0, 1'b1, 32'h0000_01fc, 16'd3, 32'h0800_0000, 32'h0000_01f0, 1'b1};
      rows[3] = '{1, 1'b1, 1'b0, 32'h0000_0300, 16'd3, 32'h0000_0080, 32'h0000_030c, 1'b1};
      rows[4] = '{5, 1'b0, 1'b0, 32'h0000_0180, 16'd1, 32'h0080_0000, 32'h0000_0184, 1'b0};
      repeat (3) @(posedge sys_clk);
      rst <= 1'b0;
      check_registers();
      for (int r = 0; r < 5; r++) begin
         if (!timed_out) begin
            run_row(r);
         end
      end
      if (!timed_out) begin
         check_priority();
      end
      $display("checks %0d, errors %0d, full writes %0d, timeouts %0d",
               chk_cnt, err_cnt, wen_err_cnt, int'(timed_out));
      if (err_cnt == 0 && wen_err_cnt == 0 && !timed_out) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end
endmodule

// ==== psx_dma.f ====
dma_pkg.sv
dma_chan_if.sv
dma_regs.sv
dma_channel.sv
dma_arbiter.sv
dma_irq.sv
dma_top.sv
dma_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run dma_tb and check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f psx_dma.f --top-module dma_tb -Mdir obj_dir -o dma_sim
	./obj_dir/dma_sim > sim.log
	@grep -q "^Test passed$$" sim.log && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log
